/* rs_settings.svh */
`ifndef RS_SETTINGS_SVH
`define RS_SETTINGS_SVH

// Bits per code symbol
`define RS_SYM_WIDTH 8

// Syndromes per codeword
`define RS_NUM_SYN 32

// Symbols in one codeword
`define RS_CODE_LEN 255

// Field polynomial x^8 + x^7 + x^2 + x + 1
`define RS_FIELD_POLY 9'h187

`endif

/* rs_pkg.sv */
`include "rs_settings.svh"

package rs_pkg;

  // One field element
  typedef logic [`RS_SYM_WIDTH-1:0] sym_t;

  // Position within a codeword
  typedef logic [7:0] sym_cnt_t;

  // All syndromes, syndrome 1 in the lowest byte
  typedef logic [`RS_NUM_SYN*`RS_SYM_WIDTH-1:0] syn_vec_t;

  // Input beat
  typedef struct packed {
    logic valid;
    logic start;
    sym_t data;
  } sym_beat_t;

  // Result of one codeword
  typedef struct packed {
    syn_vec_t syndromes;
    logic     no_error;
  } syn_result_t;

  // Framer to bank and latch
  typedef struct packed {
    logic load;
    logic step;
    logic done;
  } syn_ctrl_t;

  typedef enum logic {
    idle,
    in_word
  } framer_state_t;

  // Alpha exponent per syndrome, index 0 is syndrome 1
  localparam sym_t syn_exponent [`RS_NUM_SYN] = '{
    8'd1,   8'd10,  8'd12,  8'd21,  8'd23,  8'd32,  8'd34,  8'd43,
    8'd45,  8'd56,  8'd67,  8'd78,  8'd89,  8'd100, 8'd111, 8'd122,
    8'd133, 8'd144, 8'd155, 8'd166, 8'd177, 8'd188, 8'd199, 8'd210,
    8'd212, 8'd221, 8'd223, 8'd232, 8'd234, 8'd243, 8'd245, 8'd254
  };

  // Multiply x by alpha^power.
  // With a constant power this folds to an XOR network per output bit.
  function automatic sym_t gf_mul_alpha_pow(sym_t x, sym_t power);
    sym_t acc;
    acc = x;
    for (int i = 0; i < `RS_CODE_LEN; i++) begin
      if (i < int'(power)) begin
        // One multiply by alpha with reduction on carry out
        if (acc[`RS_SYM_WIDTH-1]) begin
          acc = {acc[`RS_SYM_WIDTH-2:0], 1'b0} ^ sym_t'(`RS_FIELD_POLY);
        end else begin
          acc = {acc[`RS_SYM_WIDTH-2:0], 1'b0};
        end
      end
    end
    return acc;
  endfunction

endpackage

/* rs_codeword_framer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rs_settings.svh"

module rs_codeword_framer (
  input  logic               clk_in,
  input  logic               rst_in,
  input  rs_pkg::sym_beat_t  beat,
  output rs_pkg::syn_ctrl_t  ctrl,
  output rs_pkg::sym_t       data
);

  rs_pkg::framer_state_t state;
  rs_pkg::sym_cnt_t      sym_cnt;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state   <= rs_pkg::idle;
      sym_cnt <= '0;
      ctrl    <= '0;
    end else begin
      // Controls are single cycle pulses
      ctrl <= '0;
      if (beat.valid) begin
        if (beat.start) begin
          // New word, also aborts a word in progress
          ctrl.load <= 1'b1;
          sym_cnt   <= rs_pkg::sym_cnt_t'(1);
          state     <= rs_pkg::in_word;
        end else begin
          case (state)
            rs_pkg::in_word: begin
              ctrl.step <= 1'b1;
              sym_cnt   <= sym_cnt + 1'b1;
              // Last symbol of the word
              if (sym_cnt == rs_pkg::sym_cnt_t'(`RS_CODE_LEN - 1)) begin
                ctrl.done <= 1'b1;
                state     <= rs_pkg::idle;
              end
            end
            default: begin
              // Stray symbols outside a word are dropped
              state <= rs_pkg::idle;
            end
          endcase
        end
      end
    end
  end

  // Symbol travels with its control pulse
  always_ff @(posedge clk_in) begin
    if (beat.valid) begin
      data <= beat.data;
    end
  end

  // A word is at least two symbols long, so done cannot repeat
  done_single_cycle: assert property (
    @(posedge clk_in) disable iff (rst_in)
    ctrl.done |=> !ctrl.done
  ) else $error("framer done high in two consecutive cycles");

  load_step_exclusive: assert property (
    @(posedge clk_in) disable iff (rst_in)
    !(ctrl.load && ctrl.step)
  ) else $error("framer load and step high together");

endmodule

`default_nettype wire

/* rs_syndrome_bank.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rs_settings.svh"

module rs_syndrome_bank (
  input  logic              clk_in,
  input  logic              rst_in,
  input  rs_pkg::syn_ctrl_t ctrl,
  input  rs_pkg::sym_t      data,
  output rs_pkg::syn_vec_t  syndromes
);

  genvar i;

  // Horner form, highest order symbol first:
  // S = r0 + a^p(r1 + a^p(r2 + ... + a^p * r254))
  for (i = 0; i < `RS_NUM_SYN; i++) begin : g_acc
    rs_pkg::sym_t acc_q;
    rs_pkg::sym_t acc_d;
    rs_pkg::sym_t acc_mul;

    assign acc_mul = rs_pkg::gf_mul_alpha_pow(acc_q, rs_pkg::syn_exponent[i]);

    always_comb begin
      if (ctrl.load) begin
        acc_d = data;
      end else if (ctrl.step) begin
        acc_d = acc_mul ^ data;
      end else begin
        acc_d = acc_q;
      end
    end

    always_ff @(posedge clk_in) begin
      if (rst_in) begin
        acc_q <= '0;
      end else begin
        acc_q <= acc_d;
      end
    end

    // Output is the value being written this cycle,
    // so the latch sees the final sum on the done cycle
    assign syndromes[i*`RS_SYM_WIDTH +: `RS_SYM_WIDTH] = acc_d;
  end

  data_known: assert property (
    @(posedge clk_in) disable iff (rst_in)
    (ctrl.load || ctrl.step) |-> !$isunknown(data)
  ) else $error("syndrome bank data unknown on load or step");

endmodule

`default_nettype wire

/* rs_syndrome_latch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rs_settings.svh"

module rs_syndrome_latch (
  input  logic                clk_in,
  input  logic                rst_in,
  input  logic                done,
  input  rs_pkg::syn_vec_t    syndromes,
  output rs_pkg::syn_result_t result,
  output logic                result_valid
);

  logic all_zero;

  // Codeword is clean when every syndrome is zero
  always_comb begin
    all_zero = 1'b1;
    for (int k = 0; k < `RS_NUM_SYN; k++) begin
      if (syndromes[k*`RS_SYM_WIDTH +: `RS_SYM_WIDTH] != '0) begin
        all_zero = 1'b0;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      result       <= '0;
      result_valid <= 1'b0;
    end else begin
      result_valid <= done;
      // Hold until the next codeword finishes
      if (done) begin
        result.syndromes <= syndromes;
        result.no_error  <= all_zero;
      end
    end
  end

  // Follows from the framer spacing done pulses apart
  valid_one_cycle: assert property (
    @(posedge clk_in) disable iff (rst_in)
    result_valid |=> !result_valid
  ) else $error("result_valid high for more than one cycle");

endmodule

`default_nettype wire

/* rs_syndrome_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rs_settings.svh"

module rs_syndrome_unit (
  input  logic                clk_in,
  input  logic                rst_in,
  input  rs_pkg::sym_beat_t   sym_in,
  output rs_pkg::syn_result_t syn_out,
  output logic                syn_valid
);

  rs_pkg::syn_ctrl_t framer_ctrl;
  rs_pkg::sym_t      framer_data;
  rs_pkg::syn_vec_t  bank_syndromes;

  // Word boundaries and control pulses
  rs_codeword_framer framer0 (
    .clk_in (clk_in),
    .rst_in (rst_in),
    .beat   (sym_in),
    .ctrl   (framer_ctrl),
    .data   (framer_data)
  );

  // One accumulator per syndrome
  rs_syndrome_bank bank0 (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .ctrl      (framer_ctrl),
    .data      (framer_data),
    .syndromes (bank_syndromes)
  );

  // Final capture and strobe
  rs_syndrome_latch latch0 (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .done         (framer_ctrl.done),
    .syndromes    (bank_syndromes),
    .result       (syn_out),
    .result_valid (syn_valid)
  );

endmodule

`default_nettype wire

/* tb_rs_model.svh */
`ifndef TB_RS_MODEL_SVH
`define TB_RS_MODEL_SVH

// Codeword being sent, index 0 is the highest order symbol
rs_pkg::sym_t word_buf [`RS_CODE_LEN];

// Shift and add multiply, reduced by the full 9-bit polynomial
function automatic rs_pkg::sym_t gf_mul_bitwise(rs_pkg::sym_t a, rs_pkg::sym_t b);
  logic [`RS_SYM_WIDTH:0] shifted;
  rs_pkg::sym_t           multiplicand;
  rs_pkg::sym_t           product;
  multiplicand = a;
  product = '0;
  for (int i = 0; i < `RS_SYM_WIDTH; i++) begin
    if (b[i]) begin
      product = product ^ multiplicand;
    end
    shifted = {multiplicand, 1'b0};
    if (shifted[`RS_SYM_WIDTH]) begin
      shifted = shifted ^ `RS_FIELD_POLY;
    end
    multiplicand = shifted[`RS_SYM_WIDTH-1:0];
  end
  return product;
endfunction

// Alpha is the element 2
function automatic rs_pkg::sym_t alpha_pow(int exponent);
  rs_pkg::sym_t value;
  value = rs_pkg::sym_t'(1);
  for (int i = 0; i < exponent; i++) begin
    value = gf_mul_bitwise(value, rs_pkg::sym_t'(2));
  end
  return value;
endfunction

function automatic rs_pkg::syn_vec_t model_syndromes();
  rs_pkg::syn_vec_t syn;
  rs_pkg::sym_t     root;
  rs_pkg::sym_t     acc;
  syn = '0;
  for (int k = 0; k < `RS_NUM_SYN; k++) begin
    root = alpha_pow(int'(rs_pkg::syn_exponent[k]));
    acc = '0;
    // Evaluate the received polynomial at this root
    for (int j = 0; j < `RS_CODE_LEN; j++) begin
      acc = gf_mul_bitwise(acc, root) ^ word_buf[j];
    end
    syn[k*`RS_SYM_WIDTH +: `RS_SYM_WIDTH] = acc;
  end
  return syn;
endfunction

function automatic logic model_no_error(rs_pkg::syn_vec_t syn);
  return (syn == '0);
endfunction

`endif

/* tb_rs_syndrome_unit.sv */
`timescale 1ns/1ps

`include "rs_settings.svh"

module tb_rs_syndrome_unit;

  localparam int CLK_PERIOD     = 40;
  localparam int DRIVE_DELAY    = 2;
  localparam int RESET_CYCLES   = 8;
  localparam int TIMEOUT_CYCLES = 20 * 300 + 100;

  logic                clk_in;
  logic                rst_in;
  rs_pkg::sym_beat_t   sym_in;
  rs_pkg::syn_result_t syn_out;
  logic                syn_valid;

  integer seed;
  int     cycle_cnt = 0;
  int     value_errors = 0;
  int     protocol_errors = 0;
  bit     result_seen = 1'b0;

  // Expected results in arrival order
  rs_pkg::syn_vec_t exp_syn_q [$];
  logic             exp_flag_q [$];
  int               exp_edge_q [$];

  `include "tb_rs_model.svh"

  rs_syndrome_unit dut0 (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .sym_in    (sym_in),
    .syn_out   (syn_out),
    .syn_valid (syn_valid)
  );

  initial begin
    clk_in = 1'b0;
    forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
  end

  // Run limit
  always @(posedge clk_in) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles with %0d results still expected",
               cycle_cnt, exp_syn_q.size());
      $display("Errors: %0d value mismatches, %0d protocol errors",
               value_errors, protocol_errors);
      $display("Test failed");
      $finish;
    end
  end

  task automatic check_syndromes(string name, rs_pkg::syn_vec_t expected,
                                 rs_pkg::syn_vec_t actual);
    if (actual !== expected) begin
      $display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
      value_errors++;
    end
  endtask

  task automatic check_flag(string name, logic expected, logic actual);
    if (actual !== expected) begin
      $display("[FAIL] %0t %s expected %b actual %b", $time, name, expected, actual);
      value_errors++;
    end
  endtask

  // One beat, driven just after the rising edge
  task automatic drive_beat(logic valid, logic start, rs_pkg::sym_t data);
    @(posedge clk_in);
    #DRIVE_DELAY;
    sym_in.valid = valid;
    sym_in.start = start;
    sym_in.data  = data;
  endtask

  task automatic drive_idle(int cycles);
    repeat (cycles) begin
      drive_beat(1'b0, 1'b0, rs_pkg::sym_t'($random(seed)));
    end
  endtask

  task automatic fill_random_word();
    for (int j = 0; j < `RS_CODE_LEN; j++) begin
      word_buf[j] = rs_pkg::sym_t'($random(seed));
    end
  endtask

  task automatic fill_constant_word(rs_pkg::sym_t value);
    for (int j = 0; j < `RS_CODE_LEN; j++) begin
      word_buf[j] = value;
    end
  endtask

  // Called right after the last symbol is driven
  task automatic expect_result();
    rs_pkg::syn_vec_t syn;
    syn = model_syndromes();
    exp_syn_q.push_back(syn);
    exp_flag_q.push_back(model_no_error(syn));
    // Sampled at the next edge, strobe one edge after that
    exp_edge_q.push_back(cycle_cnt + 2);
  endtask

  task automatic send_word(bit with_gaps);
    int gap;
    for (int j = 0; j < `RS_CODE_LEN; j++) begin
      if (with_gaps && j > 0) begin
        gap = (($random(seed) & 3) == 0) ? 1 + ($random(seed) & 1) : 0;
        drive_idle(gap);
      end
      drive_beat(1'b1, j == 0, word_buf[j]);
    end
    expect_result();
  endtask

  // Partial word that a later start beat cuts off
  task automatic send_aborted_word(int length);
    for (int j = 0; j < length; j++) begin
      drive_beat(1'b1, j == 0, word_buf[j]);
    end
  endtask

  always @(negedge clk_in) begin : result_monitor
    rs_pkg::syn_vec_t exp_syn;
    logic             exp_flag;
    int               exp_edge;
    if (!rst_in) begin
      if (syn_valid) begin
        result_seen = 1'b1;
        if (exp_syn_q.size() == 0) begin
          $display("Error at %0t: syn_valid raised with no codeword expected", $time);
          protocol_errors++;
        end else begin
          exp_syn  = exp_syn_q.pop_front();
          exp_flag = exp_flag_q.pop_front();
          exp_edge = exp_edge_q.pop_front();
          check_syndromes("syn_out.syndromes", exp_syn, syn_out.syndromes);
          check_flag("syn_out.no_error", exp_flag, syn_out.no_error);
          if (exp_edge != cycle_cnt) begin
            $display("Error at %0t: syn_valid came at edge %0d instead of edge %0d",
                     $time, cycle_cnt, exp_edge);
            protocol_errors++;
          end
        end
      end else if (!result_seen) begin
        // Output stays cleared until the first word completes
        check_syndromes("syn_out.syndromes", '0, syn_out.syndromes);
        check_flag("syn_out.no_error", 1'b0, syn_out.no_error);
      end
    end
  end

  initial begin : main_sequence
    rs_pkg::sym_t fill;
    int           missing;
    seed   = 32'h7c2aa74c;
    rst_in = 1'b1;
    sym_in = '0;
    repeat (RESET_CYCLES) @(posedge clk_in);
    #DRIVE_DELAY;
    rst_in = 1'b0;

    // Stray symbols outside a word are ignored
    drive_idle(4);
    repeat (3) begin
      drive_beat(1'b1, 1'b0, rs_pkg::sym_t'($random(seed)));
    end
    drive_idle(4);

    // Back to back random words
    repeat (10) begin
      fill_random_word();
      send_word(1'b0);
    end

    fill_constant_word('0);
    send_word(1'b0);
    fill = rs_pkg::sym_t'($random(seed));
    if (fill == '0) begin
      fill = 8'h5a;
    end
    fill_constant_word(fill);
    send_word(1'b0);
    drive_idle(3);

    // Same word with and without idle cycles
    repeat (2) begin
      fill_random_word();
      send_word(1'b1);
      send_word(1'b0);
    end
    drive_idle(2);

    // Early start aborts the word in progress
    fill_random_word();
    send_aborted_word(100);
    fill_random_word();
    send_word(1'b0);
    fill_random_word();
    send_word(1'b0);

    drive_idle(12);
    missing = exp_syn_q.size();
    if (missing != 0) begin
      $display("Error: %0d expected results never arrived", missing);
    end
    $display("Errors: %0d value mismatches, %0d protocol errors",
             value_errors, protocol_errors + missing);
    if (value_errors == 0 && protocol_errors == 0 && missing == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+.
rs_pkg.sv
rs_codeword_framer.sv
rs_syndrome_bank.sv
rs_syndrome_latch.sv
rs_syndrome_unit.sv
tb_rs_syndrome_unit.sv

/* Makefile */
# Verilator build and run for the RS syndrome unit

VERILATOR ?= verilator
TOP       ?= tb_rs_syndrome_unit
OBJ_DIR   ?= obj_dir
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Test completed successfully

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard *.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the pass message shows up in the simulation output
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
